/* dmc_cfg_decode.sv */
////////////////////
// Packs the captured config bytes into DMC fields
// A field updates the cycle after its byte's new strobe
////////////////////
`timescale 1ns/100ps

module dmc_cfg_decode (
	input  logic dfi_clk_1x_i,
	input  logic ui_clk_sync_rst_i,
	input  logic [dmc_cfg_pkg::cfg_clients_lp-1:0][dmc_cfg_pkg::tag_data_width_lp-1:0] cfg_data_i,
	input  logic [dmc_cfg_pkg::cfg_clients_lp-1:0]                                     cfg_new_i,
	output logic [dmc_cfg_pkg::trefi_width_lp-1:0]       trefi_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      tmrd_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      trfc_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      trc_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      trp_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      tras_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      trrd_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      trcd_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      twr_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      twtr_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      trtp_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      tcas_o,
	output logic [dmc_cfg_pkg::col_width_width_lp-1:0]   col_width_o,
	output logic [dmc_cfg_pkg::col_width_width_lp-1:0]   row_width_o,
	output logic [dmc_cfg_pkg::bank_width_width_lp-1:0]  bank_width_o,
	output logic [dmc_cfg_pkg::bank_pos_width_lp-1:0]    bank_pos_o,
	output logic [dmc_cfg_pkg::dqs_sel_width_lp-1:0]     dqs_sel_cal_o,
	output logic [dmc_cfg_pkg::init_cycles_width_lp-1:0] init_cycles_o,
	output logic                                         sys_reset_o,
	output logic                                         stall_transmission_o
);

	import dmc_cfg_pkg::*;

	always_ff @(posedge dfi_clk_1x_i) begin
		if (ui_clk_sync_rst_i) begin
			trefi_o <= '0;
			{tmrd_o, trfc_o, trc_o, trp_o, tras_o, trrd_o} <= '0;
			{trcd_o, twr_o, twtr_o, trtp_o, tcas_o, dqs_sel_cal_o} <= '0;
			{col_width_o, row_width_o, bank_width_o, bank_pos_o} <= '0;
			init_cycles_o        <= '0;
			sys_reset_o          <= 1'b0;
			stall_transmission_o <= 1'b0;
		end
		else begin
			// Multi-byte fields, one half per register
			if (cfg_new_i[cfg_trefi_lo_lp])
				trefi_o[tag_data_width_lp-1:0] <= cfg_data_i[cfg_trefi_lo_lp];
			if (cfg_new_i[cfg_trefi_hi_lp])
				trefi_o[trefi_width_lp-1:tag_data_width_lp] <= cfg_data_i[cfg_trefi_hi_lp];
			if (cfg_new_i[cfg_init_lo_lp])
				init_cycles_o[tag_data_width_lp-1:0] <= cfg_data_i[cfg_init_lo_lp];
			if (cfg_new_i[cfg_init_hi_lp])
				init_cycles_o[init_cycles_width_lp-1:tag_data_width_lp] <= cfg_data_i[cfg_init_hi_lp];

			// Nibble pairs with the low nibble first
			if (cfg_new_i[2])
				{trfc_o, tmrd_o} <= cfg_data_i[2];
			if (cfg_new_i[3])
				{trp_o, trc_o} <= cfg_data_i[3];
			if (cfg_new_i[4])
				{trrd_o, tras_o} <= cfg_data_i[4];
			if (cfg_new_i[5])
				{twr_o, trcd_o} <= cfg_data_i[5];
			if (cfg_new_i[6])
				{trtp_o, twtr_o} <= cfg_data_i[6];
			if (cfg_new_i[7]) begin
				tcas_o        <= cfg_data_i[7][3:0];
				dqs_sel_cal_o <= cfg_data_i[7][6:4]; // Bit 7 unused
			end
			if (cfg_new_i[8])
				{row_width_o, col_width_o} <= cfg_data_i[8];
			if (cfg_new_i[9])
				{bank_pos_o, bank_width_o} <= cfg_data_i[9];

			// Single-bit controls
			if (cfg_new_i[cfg_sys_reset_lp])
				sys_reset_o <= cfg_data_i[cfg_sys_reset_lp][0];
			if (cfg_new_i[cfg_stall_lp])
				stall_transmission_o <= cfg_data_i[cfg_stall_lp][0];
		end
	end

endmodule

/* dmc_cfg_pkg.sv */
////////////////////
// Shared constants of the DMC configuration tag path
// Packet is start bit, id MSB first, data MSB first
// Ids at or above cfg_clients_lp reach no register
////////////////////
package dmc_cfg_pkg;

	// Tag network
	localparam int cfg_clients_lp    = 14;
	localparam int tag_id_width_lp   = 4;
	localparam int tag_data_width_lp = 8;
	localparam int tag_pkt_len_lp    = 1 + tag_id_width_lp + tag_data_width_lp; // 13 bits
	localparam int tag_cnt_width_lp  = $clog2(tag_pkt_len_lp + 2); // Covers packet plus guard

	// Decoder field widths
	localparam int trefi_width_lp       = 16;
	localparam int timing_width_lp      = 4;
	localparam int col_width_width_lp   = 4;
	localparam int bank_width_width_lp  = 2;
	localparam int bank_pos_width_lp    = 6;
	localparam int dqs_sel_width_lp     = 3;
	localparam int init_cycles_width_lp = 16;

	// Register indices with a special role
	localparam int cfg_trefi_lo_lp  = 0;
	localparam int cfg_trefi_hi_lp  = 1;
	localparam int cfg_init_lo_lp   = 10;
	localparam int cfg_init_hi_lp   = 11;
	localparam int cfg_sys_reset_lp = 12;
	localparam int cfg_stall_lp     = 13;

endpackage

/* dmc_cfg_top.f */
dmc_cfg_pkg.sv
dmc_tag_master.sv
dmc_tag_client.sv
dmc_cfg_decode.sv
dmc_cfg_top.sv
tb_dmc_cfg_top.sv

/* dmc_cfg_top.sv */
////////////////////
// DMC config path of tag master, clients and decoder
// Write to field output latency is 15 cycles
// Single clock domain, no PHY
////////////////////
`timescale 1ns/100ps

module dmc_cfg_top (
	input  logic                                         dfi_clk_1x_i,
	input  logic                                         ui_clk_sync_rst_i,
	input  logic                                         cfg_wr_i,
	input  logic [dmc_cfg_pkg::tag_id_width_lp-1:0]      cfg_id_i,
	input  logic [dmc_cfg_pkg::tag_data_width_lp-1:0]    cfg_data_i,
	output logic                                         busy_o,
	output logic                                         overrun_o,
	output logic [dmc_cfg_pkg::trefi_width_lp-1:0]       trefi_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      tmrd_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      trfc_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      trc_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      trp_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      tras_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      trrd_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      trcd_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      twr_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      twtr_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      trtp_o,
	output logic [dmc_cfg_pkg::timing_width_lp-1:0]      tcas_o,
	output logic [dmc_cfg_pkg::col_width_width_lp-1:0]   col_width_o,
	output logic [dmc_cfg_pkg::col_width_width_lp-1:0]   row_width_o,
	output logic [dmc_cfg_pkg::bank_width_width_lp-1:0]  bank_width_o,
	output logic [dmc_cfg_pkg::bank_pos_width_lp-1:0]    bank_pos_o,
	output logic [dmc_cfg_pkg::dqs_sel_width_lp-1:0]     dqs_sel_cal_o,
	output logic [dmc_cfg_pkg::init_cycles_width_lp-1:0] init_cycles_o,
	output logic                                         sys_reset_o,
	output logic                                         stall_transmission_o
);

	import dmc_cfg_pkg::*;

	logic                                                tag_line; // Shared by all clients
	logic [cfg_clients_lp-1:0][tag_data_width_lp-1:0]    cfg_data;
	logic [cfg_clients_lp-1:0]                           cfg_new;

	dmc_tag_master master0 (
		.dfi_clk_1x_i      (dfi_clk_1x_i),
		.ui_clk_sync_rst_i (ui_clk_sync_rst_i),
		.cfg_wr_i          (cfg_wr_i),
		.cfg_id_i          (cfg_id_i),
		.cfg_data_i        (cfg_data_i),
		.tag_line_o        (tag_line),
		.busy_o            (busy_o),
		.overrun_o         (overrun_o)
	);

	// One listener per config register on the shared line
	for (genvar i = 0; i < cfg_clients_lp; i++) begin : g_client
		dmc_tag_client #(
			.client_id_p (tag_id_width_lp'(i))
		) client0 (
			.dfi_clk_1x_i      (dfi_clk_1x_i),
			.ui_clk_sync_rst_i (ui_clk_sync_rst_i),
			.tag_line_i        (tag_line),
			.recv_new_r_o      (cfg_new[i]),
			.recv_data_r_o     (cfg_data[i])
		);
	end

	dmc_cfg_decode decode0 (
		.dfi_clk_1x_i         (dfi_clk_1x_i),
		.ui_clk_sync_rst_i    (ui_clk_sync_rst_i),
		.cfg_data_i           (cfg_data),
		.cfg_new_i            (cfg_new),
		.trefi_o              (trefi_o),
		.tmrd_o               (tmrd_o),
		.trfc_o               (trfc_o),
		.trc_o                (trc_o),
		.trp_o                (trp_o),
		.tras_o               (tras_o),
		.trrd_o               (trrd_o),
		.trcd_o               (trcd_o),
		.twr_o                (twr_o),
		.twtr_o               (twtr_o),
		.trtp_o               (trtp_o),
		.tcas_o               (tcas_o),
		.col_width_o          (col_width_o),
		.row_width_o          (row_width_o),
		.bank_width_o         (bank_width_o),
		.bank_pos_o           (bank_pos_o),
		.dqs_sel_cal_o        (dqs_sel_cal_o),
		.init_cycles_o        (init_cycles_o),
		.sys_reset_o          (sys_reset_o),
		.stall_transmission_o (stall_transmission_o)
	);

endmodule

/* dmc_tag_client.sv */
////////////////////
// One tag listener capturing bytes sent to client_id_p
// Expects an idle low line between packets
////////////////////
`timescale 1ns/100ps

module dmc_tag_client #(
	parameter logic [dmc_cfg_pkg::tag_id_width_lp-1:0] client_id_p = '0
) (
	input  logic                                      dfi_clk_1x_i,
	input  logic                                      ui_clk_sync_rst_i,
	input  logic                                      tag_line_i,
	output logic                                      recv_new_r_o,
	output logic [dmc_cfg_pkg::tag_data_width_lp-1:0] recv_data_r_o
);

	import dmc_cfg_pkg::*;

	logic                        active_r;
	logic [tag_cnt_width_lp-1:0] cnt_r;
	logic [tag_pkt_len_lp-3:0]   shift_r; // All but the last bit after start
	logic [tag_pkt_len_lp-2:0]   pkt;     // Id and data
	logic                        last_bit;
	logic                        id_match;

	// Last bit is taken straight from the line
	assign pkt      = {shift_r, tag_line_i};
	assign last_bit = active_r & (cnt_r == tag_cnt_width_lp'(tag_pkt_len_lp - 2));
	assign id_match = (pkt[tag_pkt_len_lp-2 -: tag_id_width_lp] == client_id_p);

	always_ff @(posedge dfi_clk_1x_i) begin
		if (active_r) begin
			shift_r <= {shift_r[tag_pkt_len_lp-4:0], tag_line_i};
		end
	end

	always_ff @(posedge dfi_clk_1x_i) begin
		if (ui_clk_sync_rst_i) begin
			active_r      <= 1'b0;
			cnt_r         <= '0;
			recv_new_r_o  <= 1'b0;
			recv_data_r_o <= '0;
		end
		else begin
			recv_new_r_o <= 1'b0; // Single cycle pulse
			if (!active_r) begin
				if (tag_line_i) begin // Start bit
					active_r <= 1'b1;
					cnt_r    <= '0;
				end
			end
			else begin
				cnt_r <= cnt_r + 1'b1;
				if (last_bit) begin
					active_r <= 1'b0;
					if (id_match) begin
						recv_data_r_o <= pkt[tag_data_width_lp-1:0];
						recv_new_r_o  <= 1'b1;
					end
				end
			end
		end
	end

endmodule

/* dmc_tag_master.sv */
////////////////////
// Serializes host config writes onto one tag line
// A strobe while busy_o is high is dropped since there is no queue
// Dropped strobes set overrun_o until reset
////////////////////
`timescale 1ns/100ps

module dmc_tag_master (
	input  logic                                      dfi_clk_1x_i,
	input  logic                                      ui_clk_sync_rst_i,
	input  logic                                      cfg_wr_i,
	input  logic [dmc_cfg_pkg::tag_id_width_lp-1:0]   cfg_id_i,
	input  logic [dmc_cfg_pkg::tag_data_width_lp-1:0] cfg_data_i,
	output logic                                      tag_line_o,
	output logic                                      busy_o,
	output logic                                      overrun_o
);

	import dmc_cfg_pkg::*;

	logic [tag_pkt_len_lp-1:0]   shift_r; // MSB drives the line
	logic [tag_cnt_width_lp-1:0] cnt_r;   // Cycles left incl. guard
	logic                        accept;

	assign busy_o     = (cnt_r != '0);
	assign accept     = cfg_wr_i & ~busy_o;
	assign tag_line_o = shift_r[tag_pkt_len_lp-1];

	// Packet shifter and busy counter
	always_ff @(posedge dfi_clk_1x_i) begin
		if (ui_clk_sync_rst_i) begin
			shift_r <= '0;
			cnt_r   <= '0;
		end
		else if (accept) begin
			shift_r <= {1'b1, cfg_id_i, cfg_data_i}; // Start bit goes out next cycle
			cnt_r   <= tag_cnt_width_lp'(tag_pkt_len_lp + 1);
		end
		else begin
			// Zeros shifted in behind the data keep the guard cycle low
			shift_r <= {shift_r[tag_pkt_len_lp-2:0], 1'b0};
			if (busy_o) begin
				cnt_r <= cnt_r - 1'b1;
			end
		end
	end

	// Sticky overrun
	always_ff @(posedge dfi_clk_1x_i) begin
		if (ui_clk_sync_rst_i) begin
			overrun_o <= 1'b0;
		end
		else if (cfg_wr_i && busy_o) begin
			overrun_o <= 1'b1;
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the DMC config path testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f dmc_cfg_top.f \
	--top-module tb_dmc_cfg_top \
	-o tb_dmc_cfg_top_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_dmc_cfg_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG"
	exit 1
fi

/* tb_dmc_cfg_top.sv */
////////////////////
// Testbench for the DMC config tag path
// Expected fields come from a byte model of the 14 registers
// Assumes the fixed 15 cycle write to field latency
////////////////////
`timescale 1ns/100ps

module tb_dmc_cfg_top;

	import dmc_cfg_pkg::*;

	logic        dfi_clk_1x_i;
	logic        ui_clk_sync_rst_i;
	logic        cfg_wr_i;
	logic [3:0]  cfg_id_i;
	logic [7:0]  cfg_data_i;
	logic        busy_o, overrun_o, sys_reset_o, stall_transmission_o;
	logic [15:0] trefi_o, init_cycles_o;
	logic [3:0]  tmrd_o, trfc_o, trc_o, trp_o, tras_o, trrd_o, trcd_o, twr_o;
	logic [3:0]  twtr_o, trtp_o, tcas_o, col_width_o, row_width_o;
	logic [1:0]  bank_width_o;
	logic [5:0]  bank_pos_o;
	logic [2:0]  dqs_sel_cal_o;

	logic [7:0]  model [cfg_clients_lp]; // Last byte written to each register
	int          check_errors = 0;
	int          timeout_errors = 0;
	int          seed = 90170;
	logic [31:0] rnd;
	logic [15:0] f0, f1;

	// Table columns are id, data, first field and second field (0 where unused)
	logic [3:0]  tbl_id   [cfg_clients_lp] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13};
	logic [7:0]  tbl_data [cfg_clients_lp] = '{8'h34, 8'h12, 8'ha5, 8'h3c, 8'h96, 8'h7e,
		8'h41, 8'hdb, 8'h2f, 8'hb6, 8'h78, 8'h56, 8'h03, 8'hff};
	logic [15:0] tbl_f0   [cfg_clients_lp] = '{16'h0034, 16'h1234, 5, 12, 6, 14, 1, 11, 15,
		2, 16'h0078, 16'h5678, 1, 1};
	logic [15:0] tbl_f1   [cfg_clients_lp] = '{0, 0, 10, 3, 9, 7, 4, 5, 2, 16'h2d, 0, 0, 0, 0};

	dmc_cfg_top dut0 (.*);

	always #2 dfi_clk_1x_i = ~dfi_clk_1x_i;

	task automatic abort_run(input string what);
		timeout_errors++;
		$display("TIMEOUT: %s", what);
		$display("Errors: %0d (check %0d, timeout %0d)", check_errors + timeout_errors,
			check_errors, timeout_errors);
		$display("TESTS FAILED");
		$finish;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			check_errors++;
			$display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, exp, act);
		end
	endtask

	task automatic wait_idle();
		int cnt;
		cnt = 0;
		while (busy_o === 1'b1 && cnt < 40) begin
			@(posedge dfi_clk_1x_i);
			#0.5;
			cnt++;
		end
		if (busy_o !== 1'b0) abort_run("busy_o stayed high while waiting to issue a write");
	endtask

	// Called and returns 0.5 ns after a rising edge
	task automatic issue_write(input logic [3:0] id, input logic [7:0] data);
		wait_idle();
		cfg_id_i   = id;
		cfg_data_i = data;
		cfg_wr_i   = 1'b1;
		@(posedge dfi_clk_1x_i); // Accepted here
		#0.5;
		cfg_wr_i = 1'b0;
		check_value("busy first packet cycle", 1, busy_o);
		if (id < cfg_clients_lp) model[id] = data;
		repeat (13) @(posedge dfi_clk_1x_i);
		#0.5;
		check_value("busy guard cycle", 1, busy_o); // Cycle 14
		@(posedge dfi_clk_1x_i);
		#0.5;
		check_value("busy after guard", 0, busy_o); // Cycle 15, fields settled
	endtask

	task automatic check_all_fields(input string name);
		check_value({name, " trefi"}, {model[1], model[0]}, trefi_o);
		check_value({name, " tmrd"}, model[2][3:0], tmrd_o);
		check_value({name, " trfc"}, model[2][7:4], trfc_o);
		check_value({name, " trc"}, model[3][3:0], trc_o);
		check_value({name, " trp"}, model[3][7:4], trp_o);
		check_value({name, " tras"}, model[4][3:0], tras_o);
		check_value({name, " trrd"}, model[4][7:4], trrd_o);
		check_value({name, " trcd"}, model[5][3:0], trcd_o);
		check_value({name, " twr"}, model[5][7:4], twr_o);
		check_value({name, " twtr"}, model[6][3:0], twtr_o);
		check_value({name, " trtp"}, model[6][7:4], trtp_o);
		check_value({name, " tcas"}, model[7][3:0], tcas_o);
		check_value({name, " dqs_sel_cal"}, model[7][6:4], dqs_sel_cal_o);
		check_value({name, " col_width"}, model[8][3:0], col_width_o);
		check_value({name, " row_width"}, model[8][7:4], row_width_o);
		check_value({name, " bank_width"}, model[9][1:0], bank_width_o);
		check_value({name, " bank_pos"}, model[9][7:2], bank_pos_o);
		check_value({name, " init_cycles"}, {model[11], model[10]}, init_cycles_o);
		check_value({name, " sys_reset"}, model[12][0], sys_reset_o);
		check_value({name, " stall"}, model[13][0], stall_transmission_o);
	endtask

	// Outputs driven by one register in table column order
	task automatic get_field_pair(input int id, output logic [15:0] a, output logic [15:0] b);
		b = '0;
		case (id)
			0, 1: a = trefi_o;
			2: begin
				a = tmrd_o;
				b = trfc_o;
			end
			3: begin
				a = trc_o;
				b = trp_o;
			end
			4: begin
				a = tras_o;
				b = trrd_o;
			end
			5: begin
				a = trcd_o;
				b = twr_o;
			end
			6: begin
				a = twtr_o;
				b = trtp_o;
			end
			7: begin
				a = tcas_o;
				b = dqs_sel_cal_o;
			end
			8: begin
				a = col_width_o;
				b = row_width_o;
			end
			9: begin
				a = bank_width_o;
				b = bank_pos_o;
			end
			10, 11: a = init_cycles_o;
			12: a = sys_reset_o;
			default: a = stall_transmission_o;
		endcase
	endtask

	initial begin
		dfi_clk_1x_i      = 1'b0;
		ui_clk_sync_rst_i = 1'b1;
		cfg_wr_i          = 1'b0;
		cfg_id_i          = '0;
		cfg_data_i        = '0;
		foreach (model[i]) model[i] = '0;
		repeat (3) @(posedge dfi_clk_1x_i);
		#0.5;
		ui_clk_sync_rst_i = 1'b0;

		check_all_fields("reset");
		check_value("reset busy", 0, busy_o);
		check_value("reset overrun", 0, overrun_o);

		for (int i = 0; i < cfg_clients_lp; i++) begin
			issue_write(tbl_id[i], tbl_data[i]);
			get_field_pair(tbl_id[i], f0, f1);
			check_value($sformatf("table id %0d first", tbl_id[i]), tbl_f0[i], f0);
			check_value($sformatf("table id %0d second", tbl_id[i]), tbl_f1[i], f1);
			check_all_fields($sformatf("table id %0d", tbl_id[i]));
		end

		// Halves of 16 bit fields update on their own
		issue_write(cfg_trefi_lo_lp, 8'hef);
		check_value("trefi low only", 16'h12ef, trefi_o);
		issue_write(cfg_init_hi_lp, 8'h9a);
		check_value("init high only", 16'h9a78, init_cycles_o);
		check_all_fields("multi byte");

		issue_write(4'd14, 8'h55);
		issue_write(4'd15, 8'haa);
		check_all_fields("unused ids");
		check_value("overrun before drop", 0, overrun_o);

		// Second strobe lands two cycles into the first packet
		wait_idle();
		cfg_id_i   = 4'd5;
		cfg_data_i = 8'h11;
		cfg_wr_i   = 1'b1;
		model[5]   = 8'h11;
		@(posedge dfi_clk_1x_i);
		#0.5;
		cfg_wr_i = 1'b0;
		@(posedge dfi_clk_1x_i);
		#0.5;
		cfg_id_i   = 4'd6;
		cfg_data_i = ~model[6];
		cfg_wr_i   = 1'b1;
		@(posedge dfi_clk_1x_i);
		#0.5;
		cfg_wr_i = 1'b0;
		repeat (12) @(posedge dfi_clk_1x_i);
		#0.5;
		check_value("overrun set", 1, overrun_o);
		check_all_fields("overrun first write");
		wait_idle();
		repeat (16) @(posedge dfi_clk_1x_i);
		#0.5;
		check_all_fields("overrun dropped write");

		for (int n = 0; n < 40; n++) begin
			rnd = $random(seed);
			issue_write(4'(rnd % cfg_clients_lp), rnd[15:8]);
			check_all_fields($sformatf("random %0d", n));
		end

		$display("Errors: %0d (check %0d, timeout %0d)", check_errors + timeout_errors,
			check_errors, timeout_errors);
		if (check_errors + timeout_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
